//--- source/boot_pkg.sv
// Shared types and constants for the iNES boot path.
// Sizes are fixed here; the loader expects a 16-byte iNES header.
package boot_pkg;

  typedef logic [31:0] boot_word_t;
  typedef logic [21:0] ram_addr_t;

  // header bytes 4 to 7, in header order
  typedef struct packed {
    logic [7:0] prg_banks;
    logic [7:0] chr_banks;
    logic [7:0] flags6;
    logic [7:0] flags7;
  } mapper_flags_t;

  // 'N' 'E' 'S' 0x1A, first stream byte in the top lane
  localparam logic [31:0] INES_MAGIC = 32'h4E45_531A;

  localparam int HEADER_BYTES     = 16;
  localparam int PRG_UNIT_BYTES   = 16384;
  localparam int CHR_UNIT_BYTES   = 8192;
  localparam ram_addr_t PRG_BASE  = 22'h00_0000;
  localparam ram_addr_t CHR_BASE  = 22'h20_0000;
  localparam int FIFO_WORDS       = 8;
  localparam int LOAD_PACE        = 4;
  localparam int RAM_WRITE_CYCLES = 2;

  // derived widths
  localparam int FIFO_AW = $clog2(FIFO_WORDS);
  localparam int FIFO_CW = FIFO_AW + 3;
  localparam int PACE_W  = $clog2(LOAD_PACE);
  localparam int HDR_W   = $clog2(HEADER_BYTES);
  localparam int BUSY_W  = $clog2(RAM_WRITE_CYCLES + 1);

endpackage

//--- source/sram_write_if.sv
// Byte write channel from the loader to the SRAM write port.
// write is a one-cycle pulse and may only be raised while busy is low.
`timescale 1ns/100ps

interface sram_write_if import boot_pkg::*; ();

  ram_addr_t  addr;
  logic [7:0] data;
  logic       write;
  logic       busy;

  // loader side
  modport master (
    output addr,
    output data,
    output write,
    input  busy
  );

  // SRAM port side
  modport slave (
    input  addr,
    input  data,
    input  write,
    output busy
  );

endinterface

//--- source/boot_request_handler.sv
// Host req/ack front end. The host must drop req for a cycle after each ack.
// Counts stored bytes in steps of 4, so rom_size is taken as a word multiple.
`timescale 1ns/100ps

module boot_request_handler import boot_pkg::*; (
  input  logic        clk,
  input  logic        host_reset_loader,
  input  boot_word_t  host_bootdata,
  input  logic        host_bootdata_req,
  input  logic [31:0] rom_size,
  output logic        host_bootdata_ack,
  output logic        word_wr,
  output boot_word_t  word,
  input  logic        full
);

  typedef enum logic {S_IDLE, S_ACK} accept_state_t;

  accept_state_t state;
  logic [31:0]   bytes_loaded;
  logic          accept;

  // word presented and room for it
  assign accept = (state == S_IDLE) && host_bootdata_req && !full;

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      state             <= S_IDLE;
      host_bootdata_ack <= 1'b0;
      word_wr           <= 1'b0;
      bytes_loaded      <= '0;
    end else begin
      host_bootdata_ack <= 1'b0;
      word_wr           <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            state             <= S_ACK;
            host_bootdata_ack <= 1'b1;
            // past the image size, ack only
            if (bytes_loaded < rom_size) begin
              word_wr      <= 1'b1;
              bytes_loaded <= bytes_loaded + 32'd4;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      word <= host_bootdata;
  end

  // host must see a gap between two acks
  a_ack_single: assert property (@(posedge clk) disable iff (host_reset_loader)
    host_bootdata_ack |=> !host_bootdata_ack)
    else $error("ack held high for two cycles");

endmodule

//--- source/boot_word_fifo.sv
// Word-in, byte-out FIFO, least significant byte of each word first.
// byte_out is valid the cycle after byte_rd; full means no free word slot.
`timescale 1ns/100ps

module boot_word_fifo import boot_pkg::*; (
  input  logic       clk,
  input  logic       host_reset_loader,
  input  logic       word_wr,
  input  boot_word_t word,
  input  logic       byte_rd,
  output logic [7:0] byte_out,
  output logic       full,
  output logic       empty
);

  boot_word_t         mem_q [FIFO_WORDS];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [1:0]         lane;
  logic [FIFO_CW-1:0] byte_cnt;
  logic [FIFO_CW-1:0] used_bytes;
  logic               do_wr;
  logic               do_rd;

  // bytes still held plus bytes already taken from the head word
  assign used_bytes = byte_cnt + FIFO_CW'(lane);
  assign full       = (used_bytes >= FIFO_CW'(FIFO_WORDS * 4));
  assign empty      = (byte_cnt == '0);

  assign do_wr = word_wr && !full;
  assign do_rd = byte_rd && !empty;

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      lane     <= '0;
      byte_cnt <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) begin
        lane <= lane + 1'b1;
        // head word fully drained
        if (lane == 2'd3)
          rd_ptr <= rd_ptr + 1'b1;
      end
      byte_cnt <= byte_cnt + (do_wr ? FIFO_CW'(4) : '0) - (do_rd ? FIFO_CW'(1) : '0);
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr)
      mem_q[wr_ptr] <= word;
    if (do_rd)
      byte_out <= mem_q[rd_ptr][lane*8 +: 8];
  end

  // back-pressure from the handler keeps writes off a full FIFO
  a_no_write_full: assert property (@(posedge clk) disable iff (host_reset_loader)
    word_wr |-> !full)
    else $error("word written while FIFO full");

endmodule

//--- source/game_loader.sv
// iNES loader: 16-byte header, then PRG and CHR images copied byte by byte.
// Trainer data (flags6 bit 2) is not supported. Bytes after done/fail are dropped.
`timescale 1ns/100ps

module game_loader import boot_pkg::*; (
  input  logic          clk,
  input  logic          host_reset_loader,
  input  logic          empty,
  input  logic [7:0]    byte_out,
  output logic          byte_rd,
  sram_write_if.master  mem,
  output mapper_flags_t mapper_flags,
  output logic          loader_done,
  output logic          loader_fail
);

  typedef enum logic [2:0] {S_HEADER, S_PRG, S_CHR, S_DONE, S_FAIL} load_state_t;

  load_state_t       state;
  logic [HDR_W-1:0]  hdr_cnt;
  logic [PACE_W-1:0] pace_cnt;
  logic              byte_valid;
  logic              take;
  logic [23:0]       magic_sr;
  mapper_flags_t     flags;
  ram_addr_t         addr_cnt;
  ram_addr_t         remaining;
  ram_addr_t         prg_len;
  ram_addr_t         chr_len;

  assign prg_len = ram_addr_t'(flags.prg_banks * PRG_UNIT_BYTES);
  assign chr_len = ram_addr_t'(flags.chr_banks * CHR_UNIT_BYTES);

  // one byte in flight at a time, paced and held off by the port
  assign take = (pace_cnt == '0) && !empty && !mem.busy
                && !byte_rd && !byte_valid && !mem.write;

  assign mapper_flags = flags;

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      state       <= S_HEADER;
      hdr_cnt     <= '0;
      pace_cnt    <= '0;
      byte_rd     <= 1'b0;
      byte_valid  <= 1'b0;
      mem.write   <= 1'b0;
      loader_done <= 1'b0;
      loader_fail <= 1'b0;
      addr_cnt    <= PRG_BASE;
      remaining   <= '0;
    end else begin
      byte_valid <= byte_rd;
      mem.write  <= 1'b0;
      if (take) begin
        byte_rd  <= 1'b1;
        pace_cnt <= PACE_W'(LOAD_PACE - 1);
      end else begin
        byte_rd <= 1'b0;
        if (pace_cnt != '0)
          pace_cnt <= pace_cnt - 1'b1;
      end
      // one cycle behind the last write pulse
      if (state == S_DONE)
        loader_done <= 1'b1;
      if (byte_valid) begin
        case (state)
          S_HEADER: begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_cnt == HDR_W'(3) && {magic_sr, byte_out} != INES_MAGIC) begin
              state       <= S_FAIL;
              loader_fail <= 1'b1;
            end else if (hdr_cnt == HDR_W'(HEADER_BYTES - 1)) begin
              if (flags.prg_banks != 8'd0) begin
                state     <= S_PRG;
                addr_cnt  <= PRG_BASE;
                remaining <= prg_len;
              end else if (flags.chr_banks != 8'd0) begin
                state     <= S_CHR;
                addr_cnt  <= CHR_BASE;
                remaining <= chr_len;
              end else begin
                state <= S_DONE;
              end
            end
          end
          S_PRG, S_CHR: begin
            mem.write <= 1'b1;
            addr_cnt  <= addr_cnt + 1'b1;
            remaining <= remaining - 1'b1;
            if (remaining == ram_addr_t'(1)) begin
              if (state == S_PRG && flags.chr_banks != 8'd0) begin
                state     <= S_CHR;
                addr_cnt  <= CHR_BASE;
                remaining <= chr_len;
              end else begin
                state <= S_DONE;
              end
            end
          end
          // done or failed, byte is dropped
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_valid) begin
      if (state == S_HEADER) begin
        case (hdr_cnt)
          HDR_W'(0), HDR_W'(1), HDR_W'(2): magic_sr <= {magic_sr[15:0], byte_out};
          HDR_W'(4): flags.prg_banks <= byte_out;
          HDR_W'(5): flags.chr_banks <= byte_out;
          HDR_W'(6): flags.flags6    <= byte_out;
          HDR_W'(7): flags.flags7    <= byte_out;
          default: ;
        endcase
      end
      mem.addr <= addr_cnt;
      mem.data <= byte_out;
    end
  end

endmodule

//--- source/sram_write_port.sv
// Write-only SRAM sequencer. One byte per write pulse; we_n low for one cycle.
// busy covers RAM_WRITE_CYCLES cycles after each accepted write.
`timescale 1ns/100ps

module sram_write_port import boot_pkg::*; (
  input  logic       clk,
  input  logic       host_reset_loader,
  sram_write_if.slave mem,
  output logic       ram_we_n,
  output ram_addr_t  ram_a,
  output logic [7:0] ram_d
);

  logic [BUSY_W-1:0] busy_cnt;

  assign mem.busy = (busy_cnt != '0);

  always_ff @(posedge clk) begin
    if (host_reset_loader) begin
      ram_we_n <= 1'b1;
      busy_cnt <= '0;
    end else begin
      ram_we_n <= !mem.write;
      if (mem.write)
        busy_cnt <= BUSY_W'(RAM_WRITE_CYCLES);
      else if (busy_cnt != '0)
        busy_cnt <= busy_cnt - 1'b1;
    end
  end

  // address and data stay put while we_n is low
  always_ff @(posedge clk) begin
    if (mem.write) begin
      ram_a <= mem.addr;
      ram_d <= mem.data;
    end
  end

  // the loader must wait out busy before the next write
  a_write_not_busy: assert property (@(posedge clk) disable iff (host_reset_loader)
    mem.write |-> !mem.busy)
    else $error("SRAM write issued while busy");

endmodule

//--- source/nes_boot_loader.sv
// ROM boot path top: host handshake, word FIFO, iNES loader, SRAM write port.
// Single clock; host_reset_loader must be held while a new image is started.
`timescale 1ns/100ps

module nes_boot_loader import boot_pkg::*; (
  input  logic          clk,
  input  logic          host_reset_loader,
  input  boot_word_t    host_bootdata,
  input  logic          host_bootdata_req,
  input  logic [31:0]   rom_size,
  output logic          host_bootdata_ack,
  output logic          ram_we_n,
  output ram_addr_t     ram_a,
  output logic [7:0]    ram_d,
  output mapper_flags_t mapper_flags,
  output logic          loader_done,
  output logic          loader_fail
);

  logic       word_wr;
  boot_word_t word;
  logic       fifo_full;
  logic       fifo_empty;
  logic       byte_rd;
  logic [7:0] fifo_byte;

  sram_write_if mem_bus ();

  boot_request_handler u_handler (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .host_bootdata     (host_bootdata),
    .host_bootdata_req (host_bootdata_req),
    .rom_size          (rom_size),
    .host_bootdata_ack (host_bootdata_ack),
    .word_wr           (word_wr),
    .word              (word),
    .full              (fifo_full)
  );

  boot_word_fifo u_fifo (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .word_wr           (word_wr),
    .word              (word),
    .byte_rd           (byte_rd),
    .byte_out          (fifo_byte),
    .full              (fifo_full),
    .empty             (fifo_empty)
  );

  game_loader u_loader (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .empty             (fifo_empty),
    .byte_out          (fifo_byte),
    .byte_rd           (byte_rd),
    .mem               (mem_bus.master),
    .mapper_flags      (mapper_flags),
    .loader_done       (loader_done),
    .loader_fail       (loader_fail)
  );

  sram_write_port u_sram_port (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .mem               (mem_bus.slave),
    .ram_we_n          (ram_we_n),
    .ram_a             (ram_a),
    .ram_d             (ram_d)
  );

endmodule

//--- verif/boot_clock_gen.sv
// Clock and reset source for the boot path testbench. 40 ns clock period.
// Reset starts high at time zero; apply_reset holds it for 5 cycles.
`timescale 1ns/100ps

module boot_clock_gen (
  output logic clk,
  output logic host_reset_loader
);

  initial begin
    clk = 1'b0;
    host_reset_loader = 1'b1;
  end

  always #20 clk = ~clk;

  task automatic apply_reset();
    @(posedge clk);
    host_reset_loader <= 1'b1;
    repeat (5) @(posedge clk);
    host_reset_loader <= 1'b0;
  endtask

endmodule

//--- verif/tb_nes_boot_loader.sv
// Testbench for the iNES boot path. Plays the host, models SRAM as a queue of
// expected writes. Records come from verif/boot_tests_input.txt, run from the root.
`timescale 1ns/100ps

module tb_nes_boot_loader import boot_pkg::*; ();

  logic          clk;
  logic          host_reset_loader;
  boot_word_t    host_bootdata;
  logic          host_bootdata_req;
  logic [31:0]   rom_size;
  logic          host_bootdata_ack;
  logic          ram_we_n;
  ram_addr_t     ram_a;
  logic [7:0]    ram_d;
  mapper_flags_t mapper_flags;
  logic          loader_done;
  logic          loader_fail;

  // parsed test records
  string         rec_name [$];
  logic [127:0]  rec_hdr [$];
  logic [31:0]   rec_rom [$];
  int            rec_trail [$];
  logic          rec_done [$];
  logic          rec_fail [$];
  mapper_flags_t rec_flags [$];

  // expected SRAM writes, {address, data}
  logic [29:0]   exp_q [$];
  logic [31:0]   lfsr;
  string         cur_name;
  int            test_errs;
  int            failed_tests;
  int            load_errs;
  longint        cycle_cnt;
  longint        cycle_limit;

  boot_clock_gen clk_gen (
    .clk               (clk),
    .host_reset_loader (host_reset_loader)
  );

  nes_boot_loader uut (
    .clk               (clk),
    .host_reset_loader (host_reset_loader),
    .host_bootdata     (host_bootdata),
    .host_bootdata_req (host_bootdata_req),
    .rom_size          (rom_size),
    .host_bootdata_ack (host_bootdata_ack),
    .ram_we_n          (ram_we_n),
    .ram_a             (ram_a),
    .ram_d             (ram_d),
    .mapper_flags      (mapper_flags),
    .loader_done       (loader_done),
    .loader_fail       (loader_fail)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // one lfsr step per bit
  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      b = {lfsr[0], b[7:1]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s %s: expected %h, actual %h", cur_name, what, exp, act);
      test_errs++;
    end
  endtask

  // host side of the req/ack handshake, ack sampled mid-cycle
  task automatic send_word(input boot_word_t w);
    @(posedge clk);
    host_bootdata     <= w;
    host_bootdata_req <= 1'b1;
    do
      @(negedge clk);
    while (!host_bootdata_ack);
    @(posedge clk);
    host_bootdata_req <= 1'b0;
  endtask

  task automatic run_test(input int idx);
    logic [127:0] hdr;
    int           prg_bytes;
    int           payload_bytes;
    logic [7:0]   b;
    boot_word_t   w;
    ram_addr_t    addr;
    int           p;
    hdr       = rec_hdr[idx];
    cur_name  = rec_name[idx];
    test_errs = 0;
    exp_q.delete();
    @(posedge clk);
    rom_size          <= rec_rom[idx];
    host_bootdata_req <= 1'b0;
    clk_gen.apply_reset();
    @(negedge clk);
    check_eq("done after reset", 32'd0, loader_done);
    check_eq("fail after reset", 32'd0, loader_fail);
    for (int k = 0; k < 4; k++)
      send_word(hdr[32*k +: 32]);
    // byte 4 counts 16 KiB PRG banks, byte 5 counts 8 KiB CHR banks
    prg_bytes     = int'(hdr[39:32]) * PRG_UNIT_BYTES;
    payload_bytes = prg_bytes + int'(hdr[47:40]) * CHR_UNIT_BYTES;
    for (int i = 0; i < payload_bytes; i += 4) begin
      for (int j = 0; j < 4; j++) begin
        p = i + j;
        rand_byte(b);
        w[8*j +: 8] = b;
        if (p < prg_bytes)
          addr = PRG_BASE + ram_addr_t'(p);
        else
          addr = CHR_BASE + ram_addr_t'(p - prg_bytes);
        // bytes past rom_size never reach the FIFO
        if (!rec_fail[idx] && (HEADER_BYTES + p) < rec_rom[idx])
          exp_q.push_back({addr, b});
      end
      send_word(w);
    end
    for (int t = 0; t < rec_trail[idx]; t++) begin
      for (int j = 0; j < 4; j++) begin
        rand_byte(b);
        w[8*j +: 8] = b;
      end
      send_word(w);
    end
    if (rec_done[idx])
      while (!loader_done) @(negedge clk);
    else if (rec_fail[idx])
      while (!loader_fail) @(negedge clk);
    else
      while (exp_q.size() != 0) @(negedge clk);
    repeat (200) @(negedge clk);
    check_eq("loader_done", 32'(rec_done[idx]), loader_done);
    check_eq("loader_fail", 32'(rec_fail[idx]), loader_fail);
    // flags are only latched once the whole header is parsed
    if (!rec_fail[idx])
      check_eq("mapper_flags", rec_flags[idx], mapper_flags);
    assert (exp_q.size() == 0) else begin
      $display("%s: %0d expected SRAM writes never happened", cur_name, exp_q.size());
      test_errs++;
    end
    if (test_errs == 0) begin
      $display("test %s: ok", cur_name);
    end else begin
      $display("test %s: %0d errors", cur_name, test_errs);
      failed_tests++;
    end
  endtask

  // SRAM model, we_n is low for one full cycle
  always @(negedge clk) begin
    logic [29:0] e;
    if (!host_reset_loader && !ram_we_n) begin
      assert (exp_q.size() != 0) else begin
        $display("%s: unexpected SRAM write to %h", cur_name, ram_a);
        test_errs++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        check_eq("ram_a", 32'(e[29:8]), 32'(ram_a));
        check_eq("ram_d", 32'(e[7:0]), 32'(ram_d));
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles, in test %s",
               cycle_limit, cur_name);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [31:0] h0;
    logic [31:0] h1;
    logic [31:0] h2;
    logic [31:0] h3;
    logic [31:0] rom;
    logic [31:0] flg;
    int          trail;
    int          dn;
    int          fl;
    longint      total_bytes;
    host_bootdata     = '0;
    host_bootdata_req = 1'b0;
    rom_size          = '0;
    lfsr              = 32'h8c3c_8cd8;
    cycle_cnt         = 0;
    cycle_limit       = 64'd50_000_000;
    failed_tests      = 0;
    load_errs         = 0;
    total_bytes       = 0;
    cur_name          = "setup";
    fd = $fopen("verif/boot_tests_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/boot_tests_input.txt");
      load_errs++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %h %h %h %h %d %d %d %d %h",
                    name, h0, h1, h2, h3, rom, trail, dn, fl, flg);
        if (n == 10) begin
          rec_name.push_back(name);
          rec_hdr.push_back({h3, h2, h1, h0});
          rec_rom.push_back(rom);
          rec_trail.push_back(trail);
          rec_done.push_back(dn != 0);
          rec_fail.push_back(fl != 0);
          rec_flags.push_back(flg);
          total_bytes += HEADER_BYTES + int'(h1[7:0]) * PRG_UNIT_BYTES
                         + int'(h1[15:8]) * CHR_UNIT_BYTES + trail * 4;
        end else if (n > 0 && name.getc(0) != "#") begin
          $display("malformed test record: %s", line);
          load_errs++;
        end
      end
      $fclose(fd);
    end
    if (rec_name.size() == 0) begin
      $display("no test records were read");
      load_errs++;
    end
    cycle_limit = total_bytes * LOAD_PACE * 4 + 1000 * rec_name.size();
    for (int i = 0; i < rec_name.size(); i++)
      run_test(i);
    $display("summary: %0d run, %0d with errors, %0d record load errors",
             rec_name.size(), failed_tests, load_errs);
    if (failed_tests == 0 && load_errs == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- src.f
source/boot_pkg.sv
source/sram_write_if.sv
source/boot_request_handler.sv
source/boot_word_fifo.sv
source/game_loader.sv
source/sram_write_port.sv
source/nes_boot_loader.sv
verif/boot_clock_gen.sv
verif/tb_nes_boot_loader.sv

//--- verif/boot_tests_input.txt
# name  hdr_word0 hdr_word1 hdr_word2 hdr_word3  rom_size(dec) trailing_words  done fail  flags
# header words are little endian (first stream byte in bits 7:0), flags = {prg, chr, f6, f7}
prg_only      1A53454E 00010001 00000000 00000000 16400 0 1 0 01000100
prg_chr       1A53454E 00100101 00000000 00000000 24592 0 1 0 01011000
bad_magic     1A53454F 00010001 00000000 00000000 16400 0 0 1 00000000
rom_short     1A53454E 00000001 00000000 00000000 16392 0 0 0 01000000
trail_stored  1A53454E 01000001 00000000 00000000 16416 4 1 0 01000001
trail_dropped 1A53454E 00010001 00000000 00000000 16400 3 1 0 01000100
chr_only      1A53454E 00000100 00000000 00000000 8208  0 1 0 00010000
header_only   1A53454E 00000000 00000000 00000000 16    2 1 0 00000000
